// ==== run.sh ====
#!/usr/bin/env bash
# build and run the bus fabric simulation with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
    --top-module bus_fabric_tb -o sim_bus_fabric
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_bus_fabric)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Everything OK" <<< "$output"; then
    exit 0
fi
exit 1

// ==== source/bus_fabric.sv ====
`timescale 1ns/1ps

module bus_fabric import bus_pkg::*; #(
    parameter logic [addr_w-1:0] clint_base = 32'h0200_0000
) (
    input  logic    clock,
    input  logic    rst_n,

    input  logic    fetch_req_valid,
    input  rd_req_t fetch_req,
    output logic    fetch_req_ready,
    output logic    fetch_rsp_valid,
    output rd_rsp_t fetch_rsp,

    input  logic    data_req_valid,
    input  rd_req_t data_req,
    output logic    data_req_ready,
    output logic    data_rsp_valid,
    output rd_rsp_t data_rsp,

    output logic    ar_valid,
    output ar_t     ar,
    input  logic    ar_ready,
    input  logic    r_valid,
    input  r_t      r,
    output logic    r_ready
);

    logic        grant_valid;
    rd_req_t     grant;
    logic        fabric_idle;
    logic        done_valid;
    rd_rsp_t     done;
    logic        timer_read;
    logic [15:0] timer_offset;
    logic        timer_rsp_valid;
    rd_rsp_t     timer_rsp;

    read_arbiter read_arbiter_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_req_ready  (data_req_ready),
        .fabric_idle     (fabric_idle),
        .grant_valid     (grant_valid),
        .grant           (grant),
        .done_valid      (done_valid),
        .done            (done),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp)
    );

    read_router #(
        .clint_base (clint_base)
    ) read_router_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .grant_valid     (grant_valid),
        .grant           (grant),
        .fabric_idle     (fabric_idle),
        .done_valid      (done_valid),
        .done            (done),
        .ar_valid        (ar_valid),
        .ar              (ar),
        .ar_ready        (ar_ready),
        .r_valid         (r_valid),
        .r               (r),
        .r_ready         (r_ready),
        .timer_read      (timer_read),
        .timer_offset    (timer_offset),
        .timer_rsp_valid (timer_rsp_valid),
        .timer_rsp       (timer_rsp)
    );

    clint_timer clint_timer_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .timer_read      (timer_read),
        .timer_offset    (timer_offset),
        .timer_rsp_valid (timer_rsp_valid),
        .timer_rsp       (timer_rsp)
    );

endmodule

// ==== source/bus_pkg.sv ====
package bus_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;

    // requester side
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [id_w-1:0]   id;
    } rd_req_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic [id_w-1:0]   id;
    } rd_rsp_t;

    // master port, AXI read channels
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [id_w-1:0]   id;
    } ar_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [1:0]        resp;
        logic [id_w-1:0]   id;
    } r_t;

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;
    localparam logic [1:0] resp_decerr = 2'd3;

    localparam logic [id_w-1:0] fetch_id = 4'd0;
    localparam logic [id_w-1:0] data_id  = 4'd1;

    // clint window, 64 KiB
    localparam logic [addr_w-1:0] clint_span = 32'h0001_0000;

    localparam logic [15:0] mtime_lo_off = 16'hBFF8;
    localparam logic [15:0] mtime_hi_off = 16'hBFFC;

endpackage

// ==== source/clint_timer.sv ====
`timescale 1ns/1ps

module clint_timer import bus_pkg::*; (
    input  logic        clock,
    input  logic        rst_n,

    input  logic        timer_read,
    input  logic [15:0] timer_offset,

    output logic        timer_rsp_valid,
    output rd_rsp_t     timer_rsp
);

    logic [2*data_w-1:0] mtime;

    // free running, no write port
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            timer_rsp_valid <= 1'b0;
        end else begin
            timer_rsp_valid <= timer_read;
        end
    end

    // sample mtime as seen in the read cycle
    always_ff @(posedge clock) begin
        if (timer_read) begin
            timer_rsp.id <= '0;
            case (timer_offset)
                mtime_lo_off: begin
                    timer_rsp.data <= mtime[data_w-1:0];
                    timer_rsp.resp <= resp_okay;
                end
                mtime_hi_off: begin
                    timer_rsp.data <= mtime[2*data_w-1:data_w];
                    timer_rsp.resp <= resp_okay;
                end
                default: begin
                    timer_rsp.data <= '0;
                    timer_rsp.resp <= resp_slverr;
                end
            endcase
        end
    end

endmodule

// ==== source/read_arbiter.sv ====
`timescale 1ns/1ps

module read_arbiter import bus_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,

    input  logic    fetch_req_valid,
    input  rd_req_t fetch_req,
    output logic    fetch_req_ready,

    input  logic    data_req_valid,
    input  rd_req_t data_req,
    output logic    data_req_ready,

    input  logic    fabric_idle,
    output logic    grant_valid,
    output rd_req_t grant,

    input  logic    done_valid,
    input  rd_rsp_t done,

    output logic    fetch_rsp_valid,
    output rd_rsp_t fetch_rsp,
    output logic    data_rsp_valid,
    output rd_rsp_t data_rsp
);

    // set after a data grant, so fetch goes first out of reset
    logic last_was_data;
    logic pick_data;
    logic any_valid;

    assign any_valid = fetch_req_valid | data_req_valid;

    // data wins when alone, or when fetch had the last turn
    assign pick_data = data_req_valid & (~fetch_req_valid | ~last_was_data);

    assign grant_valid     = fabric_idle & any_valid;
    assign fetch_req_ready = fabric_idle & fetch_req_valid & ~pick_data;
    assign data_req_ready  = fabric_idle & pick_data;

    always_comb begin
        if (pick_data) begin
            grant.addr = data_req.addr;
            grant.id   = data_id;
        end else begin
            grant.addr = fetch_req.addr;
            grant.id   = fetch_id;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            last_was_data <= 1'b1;
        end else if (grant_valid) begin
            last_was_data <= pick_data;
        end
    end

    // response steering by id
    assign fetch_rsp_valid = done_valid & (done.id == fetch_id);
    assign data_rsp_valid  = done_valid & (done.id == data_id);
    assign fetch_rsp       = done;
    assign data_rsp        = done;

endmodule

// ==== source/read_router.sv ====
`timescale 1ns/1ps

module read_router import bus_pkg::*; #(
    parameter logic [addr_w-1:0] clint_base = 32'h0200_0000
) (
    input  logic        clock,
    input  logic        rst_n,

    input  logic        grant_valid,
    input  rd_req_t     grant,
    output logic        fabric_idle,
    output logic        done_valid,
    output rd_rsp_t     done,

    output logic        ar_valid,
    output ar_t         ar,
    input  logic        ar_ready,
    input  logic        r_valid,
    input  r_t          r,
    output logic        r_ready,

    output logic        timer_read,
    output logic [15:0] timer_offset,
    input  logic        timer_rsp_valid,
    input  rd_rsp_t     timer_rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_clint_wait,
        st_addr,
        st_data
    } state_t;

    localparam logic [addr_w-1:0] clint_mask = ~(clint_span - 32'd1);

    state_t            state;
    state_t            next_state;
    logic              grant_is_clint;
    logic [addr_w-1:0] hold_addr;
    logic [id_w-1:0]   hold_id;

    assign grant_is_clint = (grant.addr & clint_mask) == clint_base;

    // timer sees the read in the accept cycle
    assign timer_read   = grant_valid & grant_is_clint;
    assign timer_offset = grant.addr[15:0];

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (grant_valid) begin
                    next_state = grant_is_clint ? st_clint_wait : st_addr;
                end
            end
            st_clint_wait: begin
                if (timer_rsp_valid) begin
                    next_state = st_idle;
                end
            end
            st_addr: begin
                if (ar_ready) begin
                    next_state = st_data;
                end
            end
            st_data: begin
                if (r_valid) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (grant_valid) begin
            hold_addr <= grant.addr;
            hold_id   <= grant.id;
        end
    end

    assign fabric_idle = (state == st_idle);

    // master port
    assign ar_valid = (state == st_addr);
    assign ar.addr  = hold_addr;
    assign ar.id    = hold_id;
    assign r_ready  = (state == st_data);

    assign done_valid = ((state == st_clint_wait) & timer_rsp_valid)
                      | ((state == st_data) & r_valid);

    always_comb begin
        done.id = hold_id;
        if (state == st_clint_wait) begin
            done.data = timer_rsp.data;
            done.resp = timer_rsp.resp;
        end else begin
            done.data = r.data;
            // reply tagged for another master
            done.resp = (r.id == hold_id) ? r.resp : resp_decerr;
        end
    end

endmodule

// ==== verification/bus_fabric_asserts.sv ====
`timescale 1ns/1ps

module bus_fabric_asserts import bus_pkg::*; (
    input logic    clock,
    input logic    rst_n,
    input logic    ar_valid,
    input ar_t     ar,
    input logic    ar_ready,
    input logic    r_ready,
    input logic    done_valid,
    input rd_rsp_t done
);

    // address held under back-pressure
    ar_held: assert property (@(posedge clock) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar))
        else $error("ar changed while waiting for ar_ready");

    r_after_ar: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(r_ready) |-> $past(ar_valid && ar_ready))
        else $error("r_ready raised without an AR handshake");

    // id selects exactly one requester
    one_rsp: assert property (@(posedge clock) disable iff (!rst_n)
        done_valid |-> (done.id == fetch_id) || (done.id == data_id))
        else $error("response id matches no requester");

endmodule

bind read_router bus_fabric_asserts bus_fabric_asserts_i (
    .clock      (clock),
    .rst_n      (rst_n),
    .ar_valid   (ar_valid),
    .ar         (ar),
    .ar_ready   (ar_ready),
    .r_ready    (r_ready),
    .done_valid (done_valid),
    .done       (done)
);

// ==== verification/bus_fabric_checker.sv ====
`timescale 1ns/1ps

module bus_fabric_checker import bus_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    input  int      phase,
    input  logic    run_done,
    input  logic    fetch_req_valid,
    input  rd_req_t fetch_req,
    input  logic    fetch_req_ready,
    input  logic    fetch_rsp_valid,
    input  rd_rsp_t fetch_rsp,
    input  logic    data_req_valid,
    input  rd_req_t data_req,
    input  logic    data_req_ready,
    input  logic    data_rsp_valid,
    input  rd_rsp_t data_rsp,
    input  logic    ar_valid,
    output int      errors,
    output int      responses
);

    localparam logic [31:0] clint_base = 32'h0200_0000;

    string       names[5] = '{"fetch_only", "data_only", "mixed_arbitration",
                              "clint_timer", "error_response"};
    int          rsp_cnt[5] = '{0, 0, 0, 0, 0};
    int          err_cnt[5] = '{0, 0, 0, 0, 0};
    logic [63:0] cyc;
    logic        pend = 1'b0;
    logic        pend_is_data;
    logic        pend_clint;
    logic [63:0] pend_cyc;
    int          pend_phase;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    logic        last_data = 1'b1;
    int          shown_phase = 0;
    logic        acc_f;
    logic        acc_d;
    logic [31:0] addr;
    rd_rsp_t     got;

    initial begin
        errors    = 0;
        responses = 0;
    end

    // mtime model, cycles since reset release
    always @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 64'd1;
        end
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s %s: expected %h, actual %h",
                     names[pend_phase], what, exp, act);
            errors = errors + 1;
            err_cnt[pend_phase] = err_cnt[pend_phase] + 1;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("%s: %s", names[phase], msg);
        errors = errors + 1;
        err_cnt[phase] = err_cnt[phase] + 1;
    endtask

    always @(negedge clock) begin
        if (rst_n) begin
            if (phase != shown_phase) begin
                $display("test %s: %0d responses, %0d errors", names[shown_phase],
                         rsp_cnt[shown_phase], err_cnt[shown_phase]);
                shown_phase = phase;
            end
            if (fetch_rsp_valid && data_rsp_valid) begin
                report_problem("both requesters got a response in one cycle");
            end else if (fetch_rsp_valid || data_rsp_valid) begin
                got = data_rsp_valid ? data_rsp : fetch_rsp;
                if (!pend) begin
                    report_problem("response with no request outstanding");
                end else if (data_rsp_valid != pend_is_data) begin
                    report_problem("response went to the wrong requester");
                    pend = 1'b0;
                end else begin
                    check_value("data", exp_data, got.data);
                    check_value("resp", 32'(exp_resp), 32'(got.resp));
                    check_value("id", 32'(pend_is_data), 32'(got.id));
                    if (pend_clint) begin
                        check_value("latency", 32'd1, 32'(cyc - pend_cyc));
                    end else if (cyc - pend_cyc < 64'd2) begin
                        check_value("latency", 32'd2, 32'(cyc - pend_cyc));
                    end
                    rsp_cnt[pend_phase] = rsp_cnt[pend_phase] + 1;
                    responses = responses + 1;
                    pend = 1'b0;
                end
            end
            if (pend && pend_clint && ar_valid) begin
                report_problem("CLINT read appeared on the master port");
            end

            acc_f = fetch_req_valid && fetch_req_ready;
            acc_d = data_req_valid && data_req_ready;
            if (acc_f && acc_d) begin
                report_problem("two requests accepted in one cycle");
            end else if (acc_f || acc_d) begin
                if (pend) begin
                    report_problem("request accepted while another is outstanding");
                end
                pend_phase = phase;
                // round robin, fetch first after reset
                if (fetch_req_valid && data_req_valid) begin
                    check_value("arbitration winner", 32'(!last_data), 32'(acc_d));
                end
                last_data    = acc_d;
                pend         = 1'b1;
                pend_is_data = acc_d;
                pend_cyc     = cyc;
                addr         = acc_d ? data_req.addr : fetch_req.addr;
                pend_clint   = (addr & 32'hFFFF_0000) == clint_base;
                if (pend_clint) begin
                    exp_resp = 2'd0;
                    if (addr[15:0] == 16'hBFF8) begin
                        exp_data = cyc[31:0];
                    end else if (addr[15:0] == 16'hBFFC) begin
                        exp_data = cyc[63:32];
                    end else begin
                        exp_data = 32'h0;
                        exp_resp = 2'd2;
                    end
                end else begin
                    exp_data = ~addr;
                    exp_resp = (addr[31:28] == 4'hF) ? 2'd2 : 2'd0;
                end
            end
        end
    end

    always @(posedge run_done) begin
        $display("test %s: %0d responses, %0d errors", names[shown_phase],
                 rsp_cnt[shown_phase], err_cnt[shown_phase]);
        $display("tests: 5, responses checked: %0d, errors: %0d", responses, errors);
    end

endmodule

// ==== verification/bus_fabric_tb.sv ====
`timescale 1ns/1ps

module bus_fabric_tb import bus_pkg::*; ();

    // 200 requests at 12 cycles worst case, plus margin
    localparam int timeout_cycles = 200 * 12 + 200;
    localparam logic [31:0] clint_base = 32'h0200_0000;

    logic    clock;
    logic    rst_n;
    logic    fetch_req_valid;
    rd_req_t fetch_req;
    logic    fetch_req_ready;
    logic    fetch_rsp_valid;
    rd_rsp_t fetch_rsp;
    logic    data_req_valid;
    rd_req_t data_req;
    logic    data_req_ready;
    logic    data_rsp_valid;
    rd_rsp_t data_rsp;
    logic    ar_valid;
    ar_t     ar;
    logic    ar_ready;
    logic    r_valid;
    r_t      r;
    logic    r_ready;

    int      phase;
    logic    run_done;
    int      errors;
    int      responses;
    int      cycles;
    ar_t     held_ar;
    int      wait_cycles;

    bus_fabric #(
        .clint_base (clint_base)
    ) bus_fabric_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_req_ready  (data_req_ready),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp),
        .ar_valid        (ar_valid),
        .ar              (ar),
        .ar_ready        (ar_ready),
        .r_valid         (r_valid),
        .r               (r),
        .r_ready         (r_ready)
    );

    bus_fabric_checker checker_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .phase           (phase),
        .run_done        (run_done),
        .fetch_req_valid (fetch_req_valid),
        .fetch_req       (fetch_req),
        .fetch_req_ready (fetch_req_ready),
        .fetch_rsp_valid (fetch_rsp_valid),
        .fetch_rsp       (fetch_rsp),
        .data_req_valid  (data_req_valid),
        .data_req        (data_req),
        .data_req_ready  (data_req_ready),
        .data_rsp_valid  (data_rsp_valid),
        .data_rsp        (data_rsp),
        .ar_valid        (ar_valid),
        .errors          (errors),
        .responses       (responses)
    );

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] ext_addr();
        return {4'h1 + 4'($urandom % 8), 26'($urandom), 2'b00};
    endfunction

    function automatic logic [31:0] err_addr();
        return {4'hF, 26'($urandom), 2'b00};
    endfunction

    function automatic logic [31:0] timer_addr(input logic hi);
        return clint_base | (hi ? 32'h0000_BFFC : 32'h0000_BFF8);
    endfunction

    function automatic logic [31:0] bad_timer_addr();
        return clint_base | {16'h0, 4'h0, 10'($urandom), 2'b00};
    endfunction

    // one read, held until accepted, then wait for its response
    task automatic send(input logic is_data, input logic [31:0] addr);
        if (is_data) begin
            data_req       = '{addr: addr, id: 4'hA};
            data_req_valid = 1'b1;
            do @(negedge clock); while (!data_req_ready);
            @(posedge clock);
            #1 data_req_valid = 1'b0;
            do @(negedge clock); while (!data_rsp_valid);
        end else begin
            fetch_req       = '{addr: addr, id: 4'hA};
            fetch_req_valid = 1'b1;
            do @(negedge clock); while (!fetch_req_ready);
            @(posedge clock);
            #1 fetch_req_valid = 1'b0;
            do @(negedge clock); while (!fetch_rsp_valid);
        end
        @(posedge clock);
        #1;
    endtask

    // master port target
    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r        = '0;
        forever begin
            do begin
                @(posedge clock);
                #1;
            end while (!(rst_n && ar_valid));
            held_ar     = ar;
            wait_cycles = int'($urandom % 4);
            repeat (wait_cycles) begin
                @(posedge clock);
                #1;
            end
            ar_ready = 1'b1;
            @(posedge clock);
            #1 ar_ready = 1'b0;
            wait_cycles = int'($urandom % 4);
            repeat (wait_cycles) begin
                @(posedge clock);
                #1;
            end
            r.data  = ~held_ar.addr;
            r.resp  = (held_ar.addr[31:28] == 4'hF) ? 2'd2 : 2'd0;
            r.id    = held_ar.id;
            r_valid = 1'b1;
            // held until the fabric takes it
            do @(negedge clock); while (!r_ready);
            @(posedge clock);
            #1 r_valid = 1'b0;
        end
    end

    initial begin
        void'($urandom(32'h3b81));
        clock           = 1'b0;
        rst_n           = 1'b0;
        fetch_req_valid = 1'b0;
        fetch_req       = '0;
        data_req_valid  = 1'b0;
        data_req        = '0;
        phase           = 0;
        run_done        = 1'b0;
        cycles          = 0;
        repeat (2) @(posedge clock);
        #1 rst_n = 1'b1;
        @(posedge clock);
        #1;

        repeat (40) send(1'b0, ext_addr());
        phase = 1;
        repeat (40) send(1'b1, ext_addr());
        phase = 2;
        // both requesters run on their own, so each waits on the other
        fork
            repeat (20) send(1'b0, ext_addr());
            repeat (20) send(1'b1, ext_addr());
        join
        phase = 3;
        repeat (20) begin
            send(1'b0, timer_addr(1'($urandom)));
            send(1'b1, timer_addr(1'($urandom)));
        end
        phase = 4;
        repeat (20) begin
            send(1'($urandom), bad_timer_addr());
            send(1'($urandom), err_addr());
        end

        run_done = 1'b1;
        @(negedge clock);
        if (errors == 0 && responses == 200) begin
            $display("Everything OK");
        end else begin
            if (responses != 200) begin
                $display("only %0d of 200 requests got a response", responses);
            end
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/bus_pkg.sv
source/read_arbiter.sv
source/read_router.sv
source/clint_timer.sv
source/bus_fabric.sv
verification/bus_fabric_asserts.sv
verification/bus_fabric_checker.sv
verification/bus_fabric_tb.sv
